// ==== hw/deque_macros.svh ====
`ifndef DEQUE_MACROS_SVH
`define DEQUE_MACROS_SVH

// Bits per stored element.
`define DEQUE_WIDTH 8

// Entries per deque.
`define DEQUE_WORDS 16

// Independent deque channels.
`define DEQUE_COUNT 2

`endif

// ==== hw/deque_cmd_pkg.sv ====
package deque_cmd_pkg;

  // Push and pop strobes together mean replace.
  typedef enum logic [1:0] {
    op_nop     = 2'b00,
    op_push    = 2'b01,
    op_pop     = 2'b10,
    op_replace = 2'b11
  } deque_op_e;

  // Which end of the deque a command works on.
  typedef enum logic {
    end_front = 1'b0,
    end_back  = 1'b1
  } deque_end_e;

endpackage

// ==== hw/deque_status_pkg.sv ====
package deque_status_pkg;

  // Reason a command was refused by a deque.
  typedef enum logic [1:0] {
    rej_none      = 2'b00,
    rej_overflow  = 2'b01,
    rej_underflow = 2'b10
  } reject_e;

endpackage

// ==== hw/cmd_decoder.sv ====
`timescale 1ns/1ps
`include "deque_macros.svh"

module cmd_decoder
  import deque_cmd_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    deque_select,
  input  logic                    end_select,
  input  logic                    push,
  input  logic                    pop,
  input  logic [`DEQUE_WIDTH-1:0] data_in,
  output deque_op_e               op,
  output deque_end_e              end_sel,
  output logic [`DEQUE_COUNT-1:0] chan_en,
  output logic [`DEQUE_WIDTH-1:0] wdata
);

  deque_op_e               next_op;
  logic [`DEQUE_COUNT-1:0] next_en;

  always_comb begin
    case ({pop, push})
      2'b01:   next_op = op_push;
      2'b10:   next_op = op_pop;
      2'b11:   next_op = op_replace;
      default: next_op = op_nop;
    endcase
  end

  // Idle cycles select no channel.
  assign next_en = (next_op == op_nop) ? '0
                 : ({{(`DEQUE_COUNT-1){1'b0}}, 1'b1} << deque_select);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op      <= op_nop;
      end_sel <= end_front;
      chan_en <= '0;
    end else begin
      op      <= next_op;
      end_sel <= deque_end_e'(end_select);
      chan_en <= next_en;
    end
  end

  always_ff @(posedge clk) begin
    wdata <= data_in;
  end

  a_chan_en_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(chan_en) && ((op == op_nop) == (chan_en == '0))
  );

endmodule

// ==== hw/deque_store.sv ====
`timescale 1ns/1ps
`include "deque_macros.svh"

module deque_store
  import deque_cmd_pkg::*;
  import deque_status_pkg::*;
#(
  parameter int WORDS = `DEQUE_WORDS
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    en,
  input  deque_op_e               op,
  input  deque_end_e              end_sel,
  input  logic [`DEQUE_WIDTH-1:0] wdata,
  output logic [`DEQUE_WIDTH-1:0] peek,
  output logic                    empty,
  output logic                    full,
  output reject_e                 reject
);

  localparam int ptr_w = $clog2(WORDS);
  localparam logic [ptr_w-1:0] last_idx = ptr_w'(WORDS - 1);

  logic [`DEQUE_WIDTH-1:0] mem [WORDS];

  // Write pointers point at the next free slot on each side.
  logic [ptr_w-1:0] front_wr;
  logic [ptr_w-1:0] back_wr;
  logic [ptr_w-1:0] front_rd;
  logic [ptr_w-1:0] back_rd;
  logic [ptr_w-1:0] front_next;
  logic [ptr_w-1:0] back_next;

  logic       last_en;
  deque_end_e last_end;
  reject_e    next_reject;

  assign front_rd   = (front_wr == '0) ? last_idx : front_wr - 1'b1;
  assign back_rd    = (back_wr == last_idx) ? '0 : back_wr + 1'b1;
  assign front_next = (front_wr == last_idx) ? '0 : front_wr + 1'b1;
  assign back_next  = (back_wr == '0) ? last_idx : back_wr - 1'b1;

  // Pointers meet with data present.
  assign full = (front_wr == back_rd) && !empty;

  assign peek = (!last_en || empty) ? '0
              : (last_end == end_back) ? mem[back_rd] : mem[front_rd];

  always_comb begin
    next_reject = rej_none;
    if (en) begin
      case (op)
        op_push: begin
          if (full) begin
            next_reject = rej_overflow;
          end
        end
        op_pop, op_replace: begin
          if (empty) begin
            next_reject = rej_underflow;
          end
        end
        default: next_reject = rej_none;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      empty    <= 1'b1;
      front_wr <= '0;
      back_wr  <= last_idx;
      last_en  <= 1'b0;
      last_end <= end_front;
      reject   <= rej_none;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      last_en <= en;
      reject  <= next_reject;
      if (en) begin
        last_end <= end_sel;
      end
      if (en && next_reject == rej_none) begin
        case (op)
          op_push: begin
            empty <= 1'b0;
            if (end_sel == end_back) begin
              mem[back_wr] <= wdata;
              back_wr      <= back_next;
            end else begin
              mem[front_wr] <= wdata;
              front_wr      <= front_next;
            end
          end
          op_pop: begin
            empty <= (front_rd == back_rd); // Last element leaves.
            if (end_sel == end_back) begin
              back_wr <= back_rd;
            end else begin
              front_wr <= front_rd;
            end
          end
          op_replace: begin
            if (end_sel == end_back) begin
              mem[back_rd] <= wdata;
            end else begin
              mem[front_rd] <= wdata;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // An empty deque has its pointers in the met position.
  a_empty_pointers_meet: assert property (
    @(posedge clk) disable iff (!rst_n)
    empty |-> (front_wr == back_rd)
  );

  a_reject_needs_en: assert property (
    @(posedge clk) disable iff (!rst_n)
    !en |=> (reject == rej_none)
  );

endmodule

// ==== hw/status_reporter.sv ====
`timescale 1ns/1ps
`include "deque_macros.svh"

module status_reporter
  import deque_status_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    err_clear,
  input  logic [`DEQUE_WIDTH-1:0] peek_a,
  input  logic [`DEQUE_WIDTH-1:0] peek_b,
  input  logic [`DEQUE_COUNT-1:0] empty_in,
  input  logic [`DEQUE_COUNT-1:0] full_in,
  input  reject_e                 reject_a,
  input  reject_e                 reject_b,
  output logic [`DEQUE_WIDTH-1:0] data_out,
  output logic [`DEQUE_COUNT-1:0] empty,
  output logic [`DEQUE_COUNT-1:0] full,
  output logic                    overflow,
  output logic                    underflow
);

  logic set_overflow;
  logic set_underflow;

  assign set_overflow  = (reject_a == rej_overflow) || (reject_b == rej_overflow);
  assign set_underflow = (reject_a == rej_underflow) || (reject_b == rej_underflow);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_out  <= '0;
      empty     <= '1;
      full      <= '0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      data_out  <= peek_a | peek_b; // Idle channel peeks are zero.
      empty     <= empty_in;
      full      <= full_in;
      overflow  <= set_overflow || (overflow && !err_clear);
      underflow <= set_underflow || (underflow && !err_clear);
    end
  end

endmodule

// ==== hw/dual_deque_top.sv ====
`timescale 1ns/1ps
`include "deque_macros.svh"

module dual_deque_top
  import deque_cmd_pkg::*;
  import deque_status_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    deque_select,
  input  logic                    end_select,
  input  logic                    push,
  input  logic                    pop,
  input  logic [`DEQUE_WIDTH-1:0] data_in,
  input  logic                    err_clear,
  output logic [`DEQUE_WIDTH-1:0] data_out,
  output logic [`DEQUE_COUNT-1:0] empty,
  output logic [`DEQUE_COUNT-1:0] full,
  output logic                    overflow,
  output logic                    underflow
);

  deque_op_e               op;
  deque_end_e              end_sel;
  logic [`DEQUE_COUNT-1:0] chan_en;
  logic [`DEQUE_WIDTH-1:0] wdata;

  logic [`DEQUE_WIDTH-1:0] peek_0;
  logic [`DEQUE_WIDTH-1:0] peek_1;
  logic [`DEQUE_COUNT-1:0] deque_empty;
  logic [`DEQUE_COUNT-1:0] deque_full;
  reject_e                 reject_0;
  reject_e                 reject_1;

  cmd_decoder u_decoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .deque_select (deque_select),
    .end_select   (end_select),
    .push         (push),
    .pop          (pop),
    .data_in      (data_in),
    .op           (op),
    .end_sel      (end_sel),
    .chan_en      (chan_en),
    .wdata        (wdata)
  );

  deque_store #(
    .WORDS (`DEQUE_WORDS)
  ) u_deque_0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (chan_en[0]),
    .op      (op),
    .end_sel (end_sel),
    .wdata   (wdata),
    .peek    (peek_0),
    .empty   (deque_empty[0]),
    .full    (deque_full[0]),
    .reject  (reject_0)
  );

  deque_store #(
    .WORDS (`DEQUE_WORDS)
  ) u_deque_1 (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (chan_en[1]),
    .op      (op),
    .end_sel (end_sel),
    .wdata   (wdata),
    .peek    (peek_1),
    .empty   (deque_empty[1]),
    .full    (deque_full[1]),
    .reject  (reject_1)
  );

  status_reporter u_reporter (
    .clk       (clk),
    .rst_n     (rst_n),
    .err_clear (err_clear),
    .peek_a    (peek_0),
    .peek_b    (peek_1),
    .empty_in  (deque_empty),
    .full_in   (deque_full),
    .reject_a  (reject_0),
    .reject_b  (reject_1),
    .data_out  (data_out),
    .empty     (empty),
    .full      (full),
    .overflow  (overflow),
    .underflow (underflow)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS     = 100,
  parameter int RESET_CYCLES  = 3,
  parameter int RELEASE_DELAY = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(RELEASE_DELAY) rst_n = 1'b1; // Released just after an edge.
  end

endmodule

// ==== verification/tb_dual_deque.sv ====
`timescale 1ns/1ps
`include "deque_macros.svh"

module tb_dual_deque;

  localparam int drive_delay  = 10;
  localparam int latency      = 3; // Drive edge plus two pipeline stages.
  localparam int num_random   = 400;
  localparam int max_directed = 120;
  localparam int timeout_ns   = (max_directed + num_random) * 100 + 6000;

  typedef struct packed {
    logic [`DEQUE_WIDTH-1:0] data;
    logic [`DEQUE_COUNT-1:0] empty;
    logic [`DEQUE_COUNT-1:0] full;
    logic                    ovf;
    logic                    unf;
  } expect_t;

  logic                    clk;
  logic                    rst_n;
  logic                    deque_select;
  logic                    end_select;
  logic                    push;
  logic                    pop;
  logic                    err_clear;
  logic [`DEQUE_WIDTH-1:0] data_in;
  logic [`DEQUE_WIDTH-1:0] data_out;
  logic [`DEQUE_COUNT-1:0] empty;
  logic [`DEQUE_COUNT-1:0] full;
  logic                    overflow;
  logic                    underflow;

  logic [`DEQUE_WIDTH-1:0] ref_q0 [$]; // Index 0 is the front.
  logic [`DEQUE_WIDTH-1:0] ref_q1 [$];
  expect_t                 exp_q [$];
  int                      due_q [$];
  int                      cyc = 0;
  int                      checks = 0;
  int                      errors = 0;
  int                      tests = 0;
  int                      test_checks;
  int                      test_errors;
  string                   test_name;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) u_clock (.clk(clk), .rst_n(rst_n));

  dual_deque_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .deque_select (deque_select),
    .end_select   (end_select),
    .push         (push),
    .pop          (pop),
    .data_in      (data_in),
    .err_clear    (err_clear),
    .data_out     (data_out),
    .empty        (empty),
    .full         (full),
    .overflow     (overflow),
    .underflow    (underflow)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // Applies one command to the queues and returns what the outputs must show.
  function automatic void model_command(input logic ch, input logic back, input logic psh,
                                        input logic pp, input logic [`DEQUE_WIDTH-1:0] data,
                                        output expect_t e);
    logic [`DEQUE_WIDTH-1:0] q [$];
    if (ch) q = ref_q1;
    else q = ref_q0;
    e = '0;
    if (psh && !pp) begin
      if (q.size() == `DEQUE_WORDS) begin
        e.ovf  = 1'b1;
        e.data = back ? q[q.size()-1] : q[0]; // Peek still shows the old end.
      end else begin
        if (back) q.push_back(data);
        else q.push_front(data);
        e.data = data;
      end
    end else if (pp && !psh) begin
      if (q.size() == 0) begin
        e.unf = 1'b1;
      end else begin
        if (back) void'(q.pop_back());
        else void'(q.pop_front());
        if (q.size() != 0) e.data = back ? q[q.size()-1] : q[0];
      end
    end else if (pp && psh) begin
      if (q.size() == 0) begin
        e.unf = 1'b1;
      end else begin
        if (back) q[q.size()-1] = data;
        else q[0] = data;
        e.data = data;
      end
    end
    if (ch) ref_q1 = q;
    else ref_q0 = q;
    e.empty = {ref_q1.size() == 0, ref_q0.size() == 0};
    e.full  = {ref_q1.size() == `DEQUE_WORDS, ref_q0.size() == `DEQUE_WORDS};
  endfunction

  task automatic send_cmd(input logic ch, input logic back, input logic psh, input logic pp,
                          input logic [`DEQUE_WIDTH-1:0] data, input logic clr);
    expect_t e;
    @(posedge clk);
    #(drive_delay);
    deque_select = ch;
    end_select   = back;
    push         = psh;
    pop          = pp;
    data_in      = data;
    err_clear    = clr;
    model_command(ch, back, psh, pp, data, e);
    exp_q.push_back(e);
    due_q.push_back(cyc + latency);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic finish_test();
    @(posedge clk);
    #(drive_delay);
    push      = 1'b0;
    pop       = 1'b0;
    err_clear = 1'b0;
    while (due_q.size() != 0) @(posedge clk);
    tests++;
    $display("test %s: %s, %0d checks, %0d errors", test_name,
             (errors == test_errors) ? "passed" : "FAILED",
             checks - test_checks, errors - test_errors);
  endtask

  task automatic report_mismatch(input string field, input logic [7:0] exp, input logic [7:0] act);
    errors++;
    $display("mismatch %s %s: expected 0x%h, actual 0x%h", test_name, field, exp, act);
  endtask

  // Compare process, sampling at the falling edge where outputs are stable.
  initial begin
    expect_t e;
    logic    due_now;
    logic    clr_prev;
    logic    ovf_model;
    logic    unf_model;
    wait (rst_n === 1'b1);
    clr_prev  = err_clear;
    ovf_model = 1'b0;
    unf_model = 1'b0;
    forever begin
      @(negedge clk);
      due_now = (due_q.size() != 0) && (due_q[0] == cyc);
      e = '0;
      if (due_now) begin
        e = exp_q.pop_front();
        void'(due_q.pop_front());
      end
      ovf_model = e.ovf || (ovf_model && !clr_prev); // Set beats clear.
      unf_model = e.unf || (unf_model && !clr_prev);
      clr_prev  = err_clear;
      if (due_now) begin
        checks += 5;
        if (data_out !== e.data) report_mismatch("data_out", e.data, data_out);
        if (empty !== e.empty) report_mismatch("empty", 8'(e.empty), 8'(empty));
        if (full !== e.full) report_mismatch("full", 8'(e.full), 8'(full));
        if (overflow !== ovf_model) report_mismatch("overflow", 8'(ovf_model), 8'(overflow));
        if (underflow !== unf_model) report_mismatch("underflow", 8'(unf_model), 8'(underflow));
      end
    end
  end

  initial begin
    int   r;
    int   bias;
    logic ch;
    logic back;
    deque_select = 1'b0;
    end_select   = 1'b0;
    push         = 1'b0;
    pop          = 1'b0;
    err_clear    = 1'b0;
    data_in      = '0;
    void'($urandom(35930));
    wait (rst_n === 1'b1);

    start_test("stack_order");
    for (int i = 0; i < 8; i++) send_cmd(1'b0, 1'b0, 1'b1, 1'b0, 8'(8'h10 + i), 1'b0);
    for (int i = 0; i < 8; i++) send_cmd(1'b0, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0);
    finish_test();

    start_test("queue_order");
    for (int i = 0; i < 6; i++) send_cmd(1'b1, 1'b1, 1'b1, 1'b0, 8'(8'h20 + i), 1'b0);
    for (int i = 0; i < 6; i++) send_cmd(1'b1, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0);
    for (int i = 0; i < 6; i++) send_cmd(1'b1, 1'b0, 1'b1, 1'b0, 8'(8'h30 + i), 1'b0);
    for (int i = 0; i < 6; i++) send_cmd(1'b1, 1'b1, 1'b0, 1'b1, 8'h00, 1'b0);
    finish_test();

    start_test("full_overflow");
    for (int i = 0; i < 16; i++) send_cmd(1'b0, 1'b1, 1'b1, 1'b0, 8'(8'h40 + i), 1'b0);
    send_cmd(1'b0, 1'b1, 1'b1, 1'b0, 8'hee, 1'b0); // One too many.
    send_cmd(1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
    send_cmd(1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
    send_cmd(1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1);
    for (int i = 0; i < 16; i++) send_cmd(1'b0, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0);
    finish_test();

    start_test("underflow");
    send_cmd(1'b1, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0);
    send_cmd(1'b1, 1'b1, 1'b1, 1'b1, 8'h5a, 1'b0);
    send_cmd(1'b0, 1'b1, 1'b0, 1'b1, 8'h00, 1'b0);
    send_cmd(1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
    send_cmd(1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
    send_cmd(1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1);
    finish_test();

    start_test("replace");
    for (int i = 0; i < 3; i++) send_cmd(1'b1, 1'b1, 1'b1, 1'b0, 8'(8'ha1 + i), 1'b0);
    send_cmd(1'b1, 1'b0, 1'b1, 1'b1, 8'h5a, 1'b0);
    send_cmd(1'b1, 1'b1, 1'b1, 1'b1, 8'h5b, 1'b0);
    for (int i = 0; i < 3; i++) send_cmd(1'b1, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0);
    finish_test();

    start_test("random_mix");
    for (int i = 0; i < num_random; i++) begin
      bias = (i < num_random / 2) ? 6 : 3; // Fill first, then drain.
      r    = $urandom_range(0, 9);
      ch   = ($urandom_range(0, 1) == 1);
      back = ($urandom_range(0, 1) == 1);
      send_cmd(ch, back, (r < bias) || (r == 9), r >= bias, 8'($urandom()),
               $urandom_range(0, 7) == 0);
    end
    finish_test();

    if (checks == 0) begin
      errors++;
      $display("no DUT outputs were compared");
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns, %0d results never arrived", timeout_ns,
             due_q.size());
    $display("Something failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/deque_cmd_pkg.sv
hw/deque_status_pkg.sv
hw/cmd_decoder.sv
hw/deque_store.sv
hw/status_reporter.sv
hw/dual_deque_top.sv
verification/tb_clock_gen.sv
verification/tb_dual_deque.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_dual_deque
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := Everything OK
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
